// ==== hw/eth_test_pkg.sv ====
/*
 * ethernet traffic test types
 * port count, byte stream and counter widths, generator states
 */
package eth_test_pkg;

    // number of test ports
    localparam int NUM_PORTS  = 4;
    localparam int PORT_IDX_W = $clog2(NUM_PORTS);

    //--------------------------------------------------
    // stream and counter types
    //--------------------------------------------------
    // one byte on the mac side
    typedef logic [7:0]            byte_t;
    // frame length or idle gap
    typedef logic [15:0]           pkt_len_t;
    // frame and error counters
    typedef logic [31:0]           cnt_t;
    // one bit per port
    typedef logic [NUM_PORTS-1:0]  port_mask_t;
    // port number
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

    // generator fsm
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        PAUSE
    } gen_state_e;

endpackage

// ==== hw/axil_regs_pkg.sv ====
/*
 * axi4-lite register map of the ethernet traffic test
 */
package axil_regs_pkg;

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    typedef logic [AXIL_ADDR_W-1:0]   axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0]   axil_data_t;
    typedef logic [AXIL_DATA_W/8-1:0] axil_strb_t;
    typedef logic [1:0]               axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    //--------------------------------------------------
    // register offsets
    //--------------------------------------------------
    // start bits in the low bits, one per port
    localparam axil_addr_t REG_CTRL         = 8'h00;
    localparam axil_addr_t REG_PKT_SIZE     = 8'h04;
    localparam axil_addr_t REG_PAUSE_SIZE   = 8'h08;
    // link bits, read only
    localparam axil_addr_t REG_STATUS       = 8'h0C;
    // one word per port, read only
    localparam axil_addr_t REG_ERR_CNT_BASE = 8'h10;
    localparam axil_addr_t REG_FRM_CNT_BASE = 8'h20;

    // self-clearing counter clear
    localparam int CTRL_CLR_BIT = 24;

endpackage

// ==== hw/mac_stream_if.sv ====
/*
 * mac side byte stream, no back-pressure
 */
`timescale 1ns/100ps

interface mac_stream_if import eth_test_pkg::*; ();

    byte_t data;
    // one byte per cycle while high
    logic  valid;
    // frame markers, qualified by valid
    logic  sof;
    logic  eof;

    modport src (output data, output valid, output sof, output eof);
    modport snk (input data, input valid, input sof, input eof);

endinterface

// ==== hw/pkt_gen.sv ====
/*
 * test frame generator for one port
 * frames of pkt_size counting bytes separated by pause_size idle cycles
 */
`timescale 1ns/100ps

module pkt_gen import eth_test_pkg::*; (
    input  logic      aurora_usr_clk,
    input  logic      rst_n_i,
    input  logic      start_i,
    input  logic      link_up_i,
    input  pkt_len_t  pkt_size_i,
    input  pkt_len_t  pause_size_i,
    mac_stream_if.src tx_o
);

    gen_state_e state_q;
    // index of the byte on the stream
    pkt_len_t   byte_cnt_q;
    // length latched at sof so a frame always completes
    pkt_len_t   len_q;
    // idle cycles left minus one
    pkt_len_t   gap_q;
    logic       go;
    logic       last;

    assign go   = start_i && link_up_i && (pkt_size_i != '0);
    assign last = (byte_cnt_q == len_q - 1'b1);

    //--------------------------------------------------
    // fsm
    //--------------------------------------------------
    always_ff @(posedge aurora_usr_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            byte_cnt_q <= '0;
            len_q      <= '0;
            gap_q      <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (go) begin
                        state_q    <= SEND;
                        byte_cnt_q <= '0;
                        len_q      <= pkt_size_i;
                    end
                end
                SEND: begin
                    if (!last) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                    end else if (pause_size_i != '0) begin
                        state_q <= PAUSE;
                        gap_q   <= pause_size_i - 1'b1;
                    end else if (go) begin
                        // back to back frames
                        byte_cnt_q <= '0;
                        len_q      <= pkt_size_i;
                    end else begin
                        state_q <= IDLE;
                    end
                end
                PAUSE: begin
                    if (gap_q != '0) begin
                        gap_q <= gap_q - 1'b1;
                    end else if (go) begin
                        state_q    <= SEND;
                        byte_cnt_q <= '0;
                        len_q      <= pkt_size_i;
                    end else begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // byte k carries k
    assign tx_o.valid = (state_q == SEND);
    assign tx_o.sof   = tx_o.valid && (byte_cnt_q == '0);
    assign tx_o.eof   = tx_o.valid && last;
    assign tx_o.data  = byte_t'(byte_cnt_q);

    // the byte after an eof opens the next frame
    a_sof_after_eof: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        (tx_o.valid && $past(tx_o.eof)) |-> tx_o.sof);

    // no byte while pause cycles remain
    a_quiet_in_pause: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        ((tx_o.eof && pause_size_i != '0) || (state_q == PAUSE && gap_q != '0))
        |=> !tx_o.valid);

endmodule

// ==== hw/pkt_check.sv ====
/*
 * test frame checker for one port
 * counts received frames and frames with a wrong byte or length
 */
`timescale 1ns/100ps

module pkt_check import eth_test_pkg::*; (
    input  logic      aurora_usr_clk,
    input  logic      rst_n_i,
    input  logic      clr_i,
    input  pkt_len_t  pkt_size_i,
    mac_stream_if.snk rx_i,
    output cnt_t      err_cnt_o,
    output cnt_t      frm_cnt_o
);

    // frame open, waiting for eof
    logic     open_q;
    logic     bad_q;
    pkt_len_t idx_q;
    // byte index and error flag including the current byte
    pkt_len_t idx_c;
    logic     bad_c;
    logic     take_c;

    always_comb begin
        idx_c  = rx_i.sof ? '0 : idx_q;
        // bytes outside a frame are dropped
        take_c = rx_i.valid && (rx_i.sof || open_q);
        bad_c  = (!rx_i.sof && bad_q)
              || (rx_i.data != byte_t'(idx_c))
              || (rx_i.eof && (idx_c != pkt_size_i - 1'b1));
    end

    //--------------------------------------------------
    // frame tracking and counters
    //--------------------------------------------------
    always_ff @(posedge aurora_usr_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            open_q    <= 1'b0;
            bad_q     <= 1'b0;
            idx_q     <= '0;
            err_cnt_o <= '0;
            frm_cnt_o <= '0;
        end else begin
            if (take_c) begin
                open_q <= !rx_i.eof;
                bad_q  <= bad_c;
                idx_q  <= idx_c + 1'b1;
            end
            if (clr_i) begin
                err_cnt_o <= '0;
                frm_cnt_o <= '0;
            end else if (take_c && rx_i.eof) begin
                frm_cnt_o <= frm_cnt_o + 1'b1;
                if (bad_c) begin
                    err_cnt_o <= err_cnt_o + 1'b1;
                end
            end
        end
    end

    // a new frame only after the previous eof
    a_no_nested_sof: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        (rx_i.valid && rx_i.sof) |-> !open_q);

endmodule

// ==== hw/axil_regs.sv ====
/*
 * axi4-lite slave with the control and status registers of the test
 */
`timescale 1ns/100ps

module axil_regs
    import eth_test_pkg::*;
    import axil_regs_pkg::*;
(
    input  logic                 aurora_usr_clk,
    input  logic                 rst_n_i,
    input  axil_addr_t           s_axil_awaddr_i,
    input  logic                 s_axil_awvalid_i,
    output logic                 s_axil_awready_o,
    input  axil_data_t           s_axil_wdata_i,
    input  axil_strb_t           s_axil_wstrb_i,
    input  logic                 s_axil_wvalid_i,
    output logic                 s_axil_wready_o,
    output axil_resp_t           s_axil_bresp_o,
    output logic                 s_axil_bvalid_o,
    input  logic                 s_axil_bready_i,
    input  axil_addr_t           s_axil_araddr_i,
    input  logic                 s_axil_arvalid_i,
    output logic                 s_axil_arready_o,
    output axil_data_t           s_axil_rdata_o,
    output axil_resp_t           s_axil_rresp_o,
    output logic                 s_axil_rvalid_o,
    input  logic                 s_axil_rready_i,
    input  port_mask_t           link_up_i,
    input  cnt_t [NUM_PORTS-1:0] err_cnt_i,
    input  cnt_t [NUM_PORTS-1:0] frm_cnt_i,
    output port_mask_t           start_o,
    output logic                 clr_o,
    output pkt_len_t             pkt_size_o,
    output pkt_len_t             pause_size_o
);

    logic       wr_en;
    logic       wr_ok;
    logic       rd_en;
    logic       rd_ok;
    axil_data_t rd_data;
    // counter blocks are 16 byte aligned
    port_idx_t  cnt_idx;

    // aligned word inside a counter block
    function automatic logic cnt_hit(input axil_addr_t addr, input axil_addr_t base);
        return (addr[1:0] == 2'b00) && (addr >= base)
            && (addr < base + axil_addr_t'(4 * NUM_PORTS));
    endfunction

    //--------------------------------------------------
    // write channel
    //--------------------------------------------------
    // address and data taken together, one write in flight
    assign wr_en            = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
    assign s_axil_awready_o = wr_en;
    assign s_axil_wready_o  = wr_en;
    assign wr_ok = (s_axil_awaddr_i == REG_CTRL) || (s_axil_awaddr_i == REG_PKT_SIZE)
                || (s_axil_awaddr_i == REG_PAUSE_SIZE);

    always_ff @(posedge aurora_usr_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            start_o         <= '0;
            clr_o           <= 1'b0;
            pkt_size_o      <= '0;
            pause_size_o    <= '0;
            s_axil_bvalid_o <= 1'b0;
            s_axil_bresp_o  <= RESP_OKAY;
        end else begin
            // clear is a single pulse
            clr_o <= 1'b0;
            if (wr_en) begin
                s_axil_bvalid_o <= 1'b1;
                s_axil_bresp_o  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                case (s_axil_awaddr_i)
                    REG_CTRL: begin
                        start_o <= s_axil_wdata_i[NUM_PORTS-1:0];
                        clr_o   <= s_axil_wdata_i[CTRL_CLR_BIT];
                    end
                    REG_PKT_SIZE:   pkt_size_o   <= pkt_len_t'(s_axil_wdata_i);
                    REG_PAUSE_SIZE: pause_size_o <= pkt_len_t'(s_axil_wdata_i);
                    default: ;
                endcase
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
        end
    end

    //--------------------------------------------------
    // read channel
    //--------------------------------------------------
    assign rd_en   = s_axil_arvalid_i && s_axil_arready_o;
    assign cnt_idx = s_axil_araddr_i[2 +: PORT_IDX_W];

    // unmapped reads return 0 with slverr
    always_comb begin
        rd_data = '0;
        rd_ok   = 1'b1;
        case (s_axil_araddr_i)
            REG_CTRL:       rd_data = axil_data_t'(start_o);
            REG_PKT_SIZE:   rd_data = axil_data_t'(pkt_size_o);
            REG_PAUSE_SIZE: rd_data = axil_data_t'(pause_size_o);
            REG_STATUS:     rd_data = axil_data_t'(link_up_i);
            default: begin
                if (cnt_hit(s_axil_araddr_i, REG_ERR_CNT_BASE)) begin
                    rd_data = err_cnt_i[cnt_idx];
                end else if (cnt_hit(s_axil_araddr_i, REG_FRM_CNT_BASE)) begin
                    rd_data = frm_cnt_i[cnt_idx];
                end else begin
                    rd_ok = 1'b0;
                end
            end
        endcase
    end

    always_ff @(posedge aurora_usr_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
            s_axil_rdata_o   <= '0;
            s_axil_rresp_o   <= RESP_OKAY;
        end else if (rd_en) begin
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b1;
            s_axil_rdata_o   <= rd_data;
            s_axil_rresp_o   <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end else if (s_axil_rvalid_o && s_axil_rready_i) begin
            s_axil_rvalid_o  <= 1'b0;
            s_axil_arready_o <= 1'b1;
        end else if (!s_axil_rvalid_o) begin
            s_axil_arready_o <= 1'b1;
        end
    end

    // responses hold until taken
    a_bvalid_hold: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        (s_axil_bvalid_o && !s_axil_bready_i) |=> s_axil_bvalid_o && $stable(s_axil_bresp_o));

    a_rvalid_hold: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        (s_axil_rvalid_o && !s_axil_rready_i)
        |=> s_axil_rvalid_o && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o));

    // no byte lanes here, master must send whole words
    a_full_word: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        wr_en |-> (s_axil_wstrb_i == '1));

endmodule

// ==== hw/eth_test_top.sv ====
/*
 * ethernet traffic test top level
 * per port generator and checker behind an axi4-lite register block
 */
`timescale 1ns/100ps

module eth_test_top
    import eth_test_pkg::*;
    import axil_regs_pkg::*;
(
    input  logic                  aurora_usr_clk,
    input  logic                  rst_n_i,
    // register bus
    input  axil_addr_t            s_axil_awaddr_i,
    input  logic                  s_axil_awvalid_i,
    output logic                  s_axil_awready_o,
    input  axil_data_t            s_axil_wdata_i,
    input  axil_strb_t            s_axil_wstrb_i,
    input  logic                  s_axil_wvalid_i,
    output logic                  s_axil_wready_o,
    output axil_resp_t            s_axil_bresp_o,
    output logic                  s_axil_bvalid_o,
    input  logic                  s_axil_bready_i,
    input  axil_addr_t            s_axil_araddr_i,
    input  logic                  s_axil_arvalid_i,
    output logic                  s_axil_arready_o,
    output axil_data_t            s_axil_rdata_o,
    output axil_resp_t            s_axil_rresp_o,
    output logic                  s_axil_rvalid_o,
    input  logic                  s_axil_rready_i,
    // mac side, one lane per port
    input  port_mask_t            link_up_i,
    input  byte_t [NUM_PORTS-1:0] rx_data_i,
    input  port_mask_t            rx_valid_i,
    input  port_mask_t            rx_sof_i,
    input  port_mask_t            rx_eof_i,
    output byte_t [NUM_PORTS-1:0] tx_data_o,
    output port_mask_t            tx_valid_o,
    output port_mask_t            tx_sof_o,
    output port_mask_t            tx_eof_o
);

    port_mask_t           start;
    logic                 clr;
    pkt_len_t             pkt_size;
    pkt_len_t             pause_size;
    cnt_t [NUM_PORTS-1:0] err_cnt;
    cnt_t [NUM_PORTS-1:0] frm_cnt;

    axil_regs u_regs (
        .aurora_usr_clk   (aurora_usr_clk),
        .rst_n_i          (rst_n_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .link_up_i        (link_up_i),
        .err_cnt_i        (err_cnt),
        .frm_cnt_i        (frm_cnt),
        .start_o          (start),
        .clr_o            (clr),
        .pkt_size_o       (pkt_size),
        .pause_size_o     (pause_size)
    );

    //--------------------------------------------------
    // per port test pair
    //--------------------------------------------------
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        mac_stream_if tx_if ();
        mac_stream_if rx_if ();

        // pins to stream bundles
        assign tx_data_o[p]  = tx_if.data;
        assign tx_valid_o[p] = tx_if.valid;
        assign tx_sof_o[p]   = tx_if.sof;
        assign tx_eof_o[p]   = tx_if.eof;
        assign rx_if.data    = rx_data_i[p];
        assign rx_if.valid   = rx_valid_i[p];
        assign rx_if.sof     = rx_sof_i[p];
        assign rx_if.eof     = rx_eof_i[p];

        pkt_gen u_gen (
            .aurora_usr_clk (aurora_usr_clk),
            .rst_n_i        (rst_n_i),
            .start_i        (start[p]),
            .link_up_i      (link_up_i[p]),
            .pkt_size_i     (pkt_size),
            .pause_size_i   (pause_size),
            .tx_o           (tx_if.src)
        );

        pkt_check u_chk (
            .aurora_usr_clk (aurora_usr_clk),
            .rst_n_i        (rst_n_i),
            .clr_i          (clr),
            .pkt_size_i     (pkt_size),
            .rx_i           (rx_if.snk),
            .err_cnt_o      (err_cnt[p]),
            .frm_cnt_o      (frm_cnt[p])
        );
    end

endmodule

// ==== include/tb_axil_tasks.svh ====
/*
 * axi4-lite write and read tasks for the testbench
 * expects aurora_usr_clk and s_axil_* bus signals in the including module
 */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// one whole word write, returns bresp
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          output axil_resp_t resp);
    @(posedge aurora_usr_clk);
    #1;
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wstrb   = '1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b1;
    // awready and wready pulse together
    @(posedge aurora_usr_clk);
    while (!s_axil_awready) @(posedge aurora_usr_clk);
    check_eq("s_axil_wready", s_axil_wready, 1'b1);
    #1;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    while (!s_axil_bvalid) begin
        @(posedge aurora_usr_clk);
        #1;
    end
    resp = s_axil_bresp;
    @(posedge aurora_usr_clk);
    #1;
    s_axil_bready = 1'b0;
endtask

// one word read, returns rdata and rresp
task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                         output axil_resp_t resp);
    @(posedge aurora_usr_clk);
    #1;
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    s_axil_rready  = 1'b1;
    @(posedge aurora_usr_clk);
    while (!s_axil_arready) @(posedge aurora_usr_clk);
    #1;
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid) begin
        @(posedge aurora_usr_clk);
        #1;
    end
    data = s_axil_rdata;
    resp = s_axil_rresp;
    @(posedge aurora_usr_clk);
    #1;
    s_axil_rready = 1'b0;
endtask

`endif

// ==== dv/tb_eth_test_top.sv ====
/*
 * testbench for the ethernet traffic test top level
 * tx looped back to rx, port tests run from a table over axi4-lite
 */
`timescale 1ns/100ps

module tb_eth_test_top
    import eth_test_pkg::*;
    import axil_regs_pkg::*;
();

    localparam int    NUM_ROWS    = 7;
    localparam int    NO_CORRUPT  = -1;
    // watchdog budget per register access
    localparam int    ACC_CYCLES  = 40;
    localparam int    ACC_PER_ROW = 16;
    localparam int    ACC_FIXED   = 32;
    localparam byte_t FLIP        = 8'h5A;

    // one port test
    typedef struct packed {
        int port;
        int pkt_size;
        int pause;
        int frames;
        int bad_frame;
        int link;
    } row_t;

    logic                  aurora_usr_clk;
    logic                  rst_n;
    axil_addr_t            s_axil_awaddr;
    logic                  s_axil_awvalid;
    logic                  s_axil_awready;
    axil_data_t            s_axil_wdata;
    axil_strb_t            s_axil_wstrb;
    logic                  s_axil_wvalid;
    logic                  s_axil_wready;
    axil_resp_t            s_axil_bresp;
    logic                  s_axil_bvalid;
    logic                  s_axil_bready;
    axil_addr_t            s_axil_araddr;
    logic                  s_axil_arvalid;
    logic                  s_axil_arready;
    axil_data_t            s_axil_rdata;
    axil_resp_t            s_axil_rresp;
    logic                  s_axil_rvalid;
    logic                  s_axil_rready;
    port_mask_t            link_up;
    byte_t [NUM_PORTS-1:0] tx_data;
    byte_t [NUM_PORTS-1:0] rx_data;
    port_mask_t            tx_valid;
    port_mask_t            tx_sof;
    port_mask_t            tx_eof;

    row_t rows [NUM_ROWS];
    int   bad_byte [NUM_ROWS];
    int   seed         = 56426;
    int   limit_cycles = 0;
    int   errors       = 0;
    int   test_errs    = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    cnt_t exp_err [NUM_PORTS];
    cnt_t exp_frm [NUM_PORTS];

    // tx monitor state, counters move on the clock edge only
    logic mon_on        = 1'b0;
    int   cur_port      = 0;
    int   cur_size      = 1;
    int   cur_pause     = 0;
    int   cur_link      = 1;
    int   cur_bad_frame = NO_CORRUPT;
    int   cur_bad_byte  = 0;
    int   byte_idx      = 0;
    int   gap_cnt       = 0;
    int   frames_seen   = 0;

    `include "tb_axil_tasks.svh"

    eth_test_top dut (
        .aurora_usr_clk   (aurora_usr_clk),
        .rst_n_i          (rst_n),
        .s_axil_awaddr_i  (s_axil_awaddr),
        .s_axil_awvalid_i (s_axil_awvalid),
        .s_axil_awready_o (s_axil_awready),
        .s_axil_wdata_i   (s_axil_wdata),
        .s_axil_wstrb_i   (s_axil_wstrb),
        .s_axil_wvalid_i  (s_axil_wvalid),
        .s_axil_wready_o  (s_axil_wready),
        .s_axil_bresp_o   (s_axil_bresp),
        .s_axil_bvalid_o  (s_axil_bvalid),
        .s_axil_bready_i  (s_axil_bready),
        .s_axil_araddr_i  (s_axil_araddr),
        .s_axil_arvalid_i (s_axil_arvalid),
        .s_axil_arready_o (s_axil_arready),
        .s_axil_rdata_o   (s_axil_rdata),
        .s_axil_rresp_o   (s_axil_rresp),
        .s_axil_rvalid_o  (s_axil_rvalid),
        .s_axil_rready_i  (s_axil_rready),
        .link_up_i        (link_up),
        .rx_data_i        (rx_data),
        .rx_valid_i       (tx_valid),
        .rx_sof_i         (tx_sof),
        .rx_eof_i         (tx_eof),
        .tx_data_o        (tx_data),
        .tx_valid_o       (tx_valid),
        .tx_sof_o         (tx_sof),
        .tx_eof_o         (tx_eof)
    );

    initial begin
        aurora_usr_clk = 1'b0;
        forever #5 aurora_usr_clk = ~aurora_usr_clk;
    end

    // loopback, one byte of one frame flipped on request
    always_comb begin
        rx_data = tx_data;
        if (cur_bad_frame >= 0 && tx_valid[cur_port] && frames_seen == cur_bad_frame
            && byte_idx == cur_bad_byte) begin
            rx_data[cur_port] = tx_data[cur_port] ^ FLIP;
        end
    end

    //--------------------------------------------------
    // check helpers
    //--------------------------------------------------
    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            count_error();
        end
    endtask

    task automatic fault(input string what);
        $display("Error: %s at %0t", what, $time);
        count_error();
    endtask

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                             input axil_resp_t exp_resp);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        check_eq($sformatf("s_axil_bresp @0x%02h", addr), resp, exp_resp);
    endtask

    task automatic expect_reg(input axil_addr_t addr, input axil_data_t exp_data,
                              input axil_resp_t exp_resp);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(addr, data, resp);
        check_eq($sformatf("s_axil_rresp @0x%02h", addr), resp, exp_resp);
        check_eq($sformatf("s_axil_rdata @0x%02h", addr), data, exp_data);
    endtask

    // all ports, so untouched ports are covered too
    task automatic expect_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            expect_reg(axil_addr_t'(REG_ERR_CNT_BASE + 4 * p), exp_err[p], RESP_OKAY);
            expect_reg(axil_addr_t'(REG_FRM_CNT_BASE + 4 * p), exp_frm[p], RESP_OKAY);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    //--------------------------------------------------
    // tx frame monitor
    //--------------------------------------------------
    always @(posedge aurora_usr_clk) begin
        if (mon_on) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (p != cur_port) begin
                    assert (!tx_valid[p]) else fault($sformatf("tx valid on idle port %0d", p));
                end
            end
            if (tx_valid[cur_port]) begin
                assert (cur_link != 0) else fault("tx valid while the link is down");
                check_eq("tx_sof", tx_sof[cur_port], byte_idx == 0);
                check_eq("tx_data", tx_data[cur_port], byte_idx % 256);
                check_eq("tx_eof", tx_eof[cur_port], byte_idx == cur_size - 1);
                // idle cycles since the previous eof
                if (byte_idx == 0 && frames_seen > 0) begin
                    check_eq("tx idle gap", gap_cnt, cur_pause);
                end
                if (byte_idx == cur_size - 1) begin
                    byte_idx    <= 0;
                    gap_cnt     <= 0;
                    frames_seen <= frames_seen + 1;
                end else begin
                    byte_idx <= byte_idx + 1;
                end
            end else begin
                assert (byte_idx == 0) else begin
                    fault("tx valid dropped inside a frame");
                    byte_idx <= 0;
                end
                gap_cnt <= gap_cnt + 1;
            end
        end
    end

    //--------------------------------------------------
    // test table
    //--------------------------------------------------
    task automatic load_table();
        // port, size, pause, frames, corrupt frame, link
        rows[0] = '{0, 1, 0, 6, NO_CORRUPT, 1};
        rows[1] = '{1, 2, 3, 5, NO_CORRUPT, 1};
        rows[2] = '{2, 17, 1, 4, 2, 1};
        rows[3] = '{3, 64, 5, 3, NO_CORRUPT, 1};
        rows[4] = '{1, 64, 2, 3, 0, 1};
        rows[5] = '{2, 17, 4, 3, NO_CORRUPT, 0};
        rows[6] = '{0, 2, 0, 4, 3, 1};
        limit_cycles = ACC_FIXED * ACC_CYCLES;
        for (int r = 0; r < NUM_ROWS; r++) begin
            bad_byte[r]  = {$random(seed)} % rows[r].pkt_size;
            limit_cycles += rows[r].frames * (rows[r].pkt_size + rows[r].pause + 2)
                          + ACC_PER_ROW * ACC_CYCLES;
        end
    endtask

    task automatic run_row(input int r);
        int quiet;
        cur_port      = rows[r].port;
        cur_size      = rows[r].pkt_size;
        cur_pause     = rows[r].pause;
        cur_link      = rows[r].link;
        cur_bad_frame = NO_CORRUPT;
        byte_idx      = 0;
        gap_cnt       = 0;
        frames_seen   = 0;
        write_reg(REG_PKT_SIZE, axil_data_t'(cur_size), RESP_OKAY);
        write_reg(REG_PAUSE_SIZE, axil_data_t'(cur_pause), RESP_OKAY);
        link_up[cur_port] = (cur_link != 0);
        if (cur_link != 0) begin
            cur_bad_frame = rows[r].bad_frame;
            cur_bad_byte  = bad_byte[r];
        end
        write_reg(REG_CTRL, axil_data_t'(1) << cur_port, RESP_OKAY);
        if (cur_link != 0) begin
            while (frames_seen < rows[r].frames) @(posedge aurora_usr_clk);
            #1;
        end else begin
            // nothing may come out, give it the time of the frames
            repeat (rows[r].frames * (cur_size + cur_pause + 2)) @(posedge aurora_usr_clk);
            #1;
            expect_reg(REG_STATUS, axil_data_t'(link_up), RESP_OKAY);
        end
        write_reg(REG_CTRL, '0, RESP_OKAY);
        // idle once valid stays low past the pause
        quiet = 0;
        while (quiet < cur_pause + 2) begin
            @(posedge aurora_usr_clk);
            #1;
            if (tx_valid[cur_port]) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        assert (byte_idx == 0) else fault("frame still open after stop");
        if (cur_link == 0) begin
            check_eq("tx frame count", frames_seen, 0);
        end
        exp_frm[cur_port] += cnt_t'(frames_seen);
        if (cur_bad_frame >= 0) begin
            exp_err[cur_port] += 1;
        end
        cur_bad_frame = NO_CORRUPT;
        expect_counters();
        link_up[cur_port] = 1'b1;
        end_test($sformatf("row %0d port %0d size %0d pause %0d link %0d", r, cur_port,
                           cur_size, cur_pause, cur_link));
    endtask

    // ends the run if the table does not finish in time
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge aurora_usr_clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    //--------------------------------------------------
    // main sequence
    //--------------------------------------------------
    initial begin
        rst_n          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        link_up        = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_err[p] = '0;
            exp_frm[p] = '0;
        end
        load_table();
        repeat (3) @(posedge aurora_usr_clk);
        #1;
        rst_n = 1'b1;

        // reset values, then size registers read back
        expect_reg(REG_CTRL, '0, RESP_OKAY);
        expect_reg(REG_PKT_SIZE, '0, RESP_OKAY);
        expect_reg(REG_PAUSE_SIZE, '0, RESP_OKAY);
        expect_reg(REG_STATUS, '0, RESP_OKAY);
        expect_counters();
        link_up = '1;
        expect_reg(REG_STATUS, axil_data_t'(link_up), RESP_OKAY);
        write_reg(REG_PKT_SIZE, 32'h0000_1234, RESP_OKAY);
        write_reg(REG_PAUSE_SIZE, 32'h0000_00A5, RESP_OKAY);
        expect_reg(REG_PKT_SIZE, 32'h0000_1234, RESP_OKAY);
        expect_reg(REG_PAUSE_SIZE, 32'h0000_00A5, RESP_OKAY);
        end_test("reset values and readback");

        mon_on = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        // counter clear, bit itself not stored
        write_reg(REG_CTRL, axil_data_t'(1) << CTRL_CLR_BIT, RESP_OKAY);
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_err[p] = '0;
            exp_frm[p] = '0;
        end
        expect_counters();
        expect_reg(REG_CTRL, '0, RESP_OKAY);
        end_test("counter clear");

        // unmapped and read only addresses
        write_reg(8'h40, 32'hFFFF_FFFF, RESP_SLVERR);
        write_reg(REG_STATUS, 32'h0000_0000, RESP_SLVERR);
        write_reg(REG_FRM_CNT_BASE, 32'h0000_0055, RESP_SLVERR);
        expect_reg(8'h40, '0, RESP_SLVERR);
        expect_reg(8'h30, '0, RESP_SLVERR);
        expect_reg(8'h11, '0, RESP_SLVERR);
        expect_reg(REG_PKT_SIZE, axil_data_t'(rows[NUM_ROWS-1].pkt_size), RESP_OKAY);
        expect_counters();
        end_test("unmapped access");

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
hw/eth_test_pkg.sv
hw/axil_regs_pkg.sv
hw/mac_stream_if.sv
hw/pkt_gen.sv
hw/pkt_check.sv
hw/axil_regs.sv
hw/eth_test_top.sv
dv/tb_eth_test_top.sv
